/* ptw_pkg.sv */
// Sv32 widths and shared types for the page-table walker
// widths are fixed by the privileged spec and are not meant to be changed
package ptw_pkg;

  localparam int unsigned VA_W   = 32;
  localparam int unsigned PA_W   = 34;
  localparam int unsigned PPN_W  = 22;
  localparam int unsigned VPN_W  = 20;
  localparam int unsigned ASID_W = 9;
  localparam int unsigned PTE_W  = 32;
  // AXI read response encoding
  localparam int unsigned RESP_W = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY = 2'b00;

  // --------------------
  // page-table entry, one word, msb first
  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic [1:0]       rsw;
    logic             d;
    logic             a;
    logic             g;
    logic             u;
    logic             x;
    logic             w;
    logic             r;
    logic             v;
  } pte_t;

  typedef enum logic [1:0] {V_LEAF, V_POINTER, V_FAULT} verdict_e;
  typedef enum logic [1:0] {F_NONE, F_PAGE, F_ACCESS} fault_e;
  typedef enum logic [2:0] {S_IDLE, S_AR, S_R, S_CHECK, S_EMIT} walk_state_e;
  // Sv32 has two levels, LVL1 is the root
  typedef enum logic {LVL1, LVL2} level_e;

  // --------------------
  // walk context captured at the miss handshake
  typedef struct packed {
    logic [VA_W-1:0]   vaddr;
    logic [ASID_W-1:0] asid;
    logic              is_instr;
    logic              is_store;
    logic              mxr;
  } miss_req_t;

  // record handed to the shared TLB
  typedef struct packed {
    pte_t              pte;
    logic [VPN_W-1:0]  vpn;
    logic [ASID_W-1:0] asid;
    logic              is_4m;
    fault_e            fault;
  } tlb_rec_t;

endpackage

/* ptw_res_if.sv */
// finished walk record from the walker into the result buffer
// a record transfers when valid and ready are both high
`timescale 1ns/10ps

interface ptw_res_if;

  // record is held by the walker until ready
  logic valid;
  logic ready;
  ptw_pkg::tlb_rec_t rec;

  // walker side drives the record
  modport walker (
    output valid,
    output rec,
    input  ready
  );

  // buffer side accepts it
  modport buffer (
    input  valid,
    input  rec,
    output ready
  );

endinterface

/* pte_decode.sv */
// classifies one Sv32 PTE as leaf, pointer or page fault
// purely combinational, A/D bits are never updated in hardware
`timescale 1ns/10ps

module pte_decode (
  input  ptw_pkg::pte_t     pte_i,
  input  ptw_pkg::level_e   level_i,
  input  logic              is_instr_i,
  input  logic              is_store_i,
  input  logic              mxr_i,
  output ptw_pkg::verdict_e verdict_o
);

  logic is_invalid;
  logic is_leaf;
  logic instr_bad;
  logic data_bad;
  logic store_bad;
  logic misaligned;

  // --------------------
  // basic entry checks
  // v clear, or write-only which is reserved
  assign is_invalid = !pte_i.v || (pte_i.w && !pte_i.r);
  // r or x set means leaf, otherwise pointer to next level
  assign is_leaf    = pte_i.r || pte_i.x;

  // --------------------
  // permission checks on a leaf
  // fetch needs x, and a since A is left to software
  assign instr_bad  = !pte_i.x || !pte_i.a;
  // loads need a and r, or x when MXR makes executable readable
  assign data_bad   = !pte_i.a || !(pte_i.r || (pte_i.x && mxr_i));
  // store needs w, and d is also managed by software
  assign store_bad  = is_store_i && (!pte_i.w || !pte_i.d);
  // 4M superpage must have ppn[9:0] clear
  assign misaligned = (level_i == ptw_pkg::LVL1) && (pte_i.ppn[9:0] != '0);

  always_comb begin
    verdict_o = ptw_pkg::V_POINTER;
    if (is_invalid) begin
      verdict_o = ptw_pkg::V_FAULT;
    end else if (is_leaf) begin
      verdict_o = ptw_pkg::V_LEAF;
      if (is_instr_i) begin
        if (instr_bad) begin
          verdict_o = ptw_pkg::V_FAULT;
        end
      end else if (data_bad || store_bad) begin
        // store check only applies on the data side
        verdict_o = ptw_pkg::V_FAULT;
      end
      if (misaligned) begin
        verdict_o = ptw_pkg::V_FAULT;
      end
    end else if (level_i == ptw_pkg::LVL2) begin
      // no third level in Sv32
      verdict_o = ptw_pkg::V_FAULT;
    end
  end

endmodule

/* ptw_walk.sv */
// Sv32 walk FSM, one outstanding AXI4-Lite read at a time
// a non-OKAY read response ends the walk with an access fault
`timescale 1ns/10ps

module ptw_walk (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // miss request
  input  logic                        miss_valid_i,
  output logic                        miss_ready_o,
  input  logic [ptw_pkg::VA_W-1:0]    vaddr_i,
  input  logic [ptw_pkg::ASID_W-1:0]  asid_i,
  input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn_i,
  input  logic                        is_instr_i,
  input  logic                        is_store_i,
  input  logic                        mxr_i,
  // AXI4-Lite read channels
  output logic                        ar_valid_o,
  input  logic                        ar_ready_i,
  output logic [ptw_pkg::PA_W-1:0]    ar_addr_o,
  input  logic                        r_valid_i,
  output logic                        r_ready_o,
  input  logic [ptw_pkg::PTE_W-1:0]   r_data_i,
  input  logic [ptw_pkg::RESP_W-1:0]  r_resp_i,
  // record towards the result buffer
  ptw_res_if.walker                   res,
  // PTE decode
  input  ptw_pkg::verdict_e           verdict_i,
  output ptw_pkg::pte_t               pte_o,
  output ptw_pkg::level_e             level_o
);

  ptw_pkg::walk_state_e state_q;
  ptw_pkg::level_e      level_q;
  logic                 init_q;
  logic                 glob_q;
  ptw_pkg::miss_req_t   ctx_q;
  logic [ptw_pkg::PA_W-1:0] ptr_q;
  ptw_pkg::pte_t        pte_q;
  logic                 resp_err_q;

  logic              accept;
  logic              r_fire;
  logic              descend;
  ptw_pkg::fault_e   fault;
  ptw_pkg::tlb_rec_t rec;

  // --------------------
  // handshakes
  // ready held low for the first cycle out of reset
  assign miss_ready_o = (state_q == ptw_pkg::S_IDLE) && init_q;
  assign accept       = miss_valid_i && miss_ready_o;
  assign ar_valid_o   = (state_q == ptw_pkg::S_AR);
  assign ar_addr_o    = ptr_q;
  assign r_ready_o    = (state_q == ptw_pkg::S_R);
  assign r_fire       = r_valid_i && r_ready_o;
  // good read of a pointer at level 1, go one level down
  assign descend      = (state_q == ptw_pkg::S_CHECK) && !resp_err_q &&
                        (verdict_i == ptw_pkg::V_POINTER);

  // registered PTE goes to decode
  assign pte_o   = pte_q;
  assign level_o = level_q;

  // --------------------
  // FSM and control
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ptw_pkg::S_IDLE;
      level_q <= ptw_pkg::LVL1;
      init_q  <= 1'b0;
      glob_q  <= 1'b0;
    end else begin
      init_q <= 1'b1;
      case (state_q)
        ptw_pkg::S_IDLE: begin
          if (accept) begin
            level_q <= ptw_pkg::LVL1;
            glob_q  <= 1'b0;
            state_q <= ptw_pkg::S_AR;
          end
        end
        ptw_pkg::S_AR: begin
          if (ar_ready_i) begin
            state_q <= ptw_pkg::S_R;
          end
        end
        ptw_pkg::S_R: begin
          if (r_fire) begin
            state_q <= ptw_pkg::S_CHECK;
          end
        end
        ptw_pkg::S_CHECK: begin
          if (descend) begin
            level_q <= ptw_pkg::LVL2;
            // global from the root pointer covers the whole subtree
            glob_q  <= glob_q | pte_q.g;
            state_q <= ptw_pkg::S_AR;
          end else begin
            state_q <= ptw_pkg::S_EMIT;
          end
        end
        ptw_pkg::S_EMIT: begin
          if (res.ready) begin
            state_q <= ptw_pkg::S_IDLE;
          end
        end
        default: state_q <= ptw_pkg::S_IDLE;
      endcase
    end
  end

  // --------------------
  // walk context, pointer and read data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ctx_q.vaddr    <= vaddr_i;
      ctx_q.asid     <= asid_i;
      ctx_q.is_instr <= is_instr_i;
      ctx_q.is_store <= is_store_i;
      ctx_q.mxr      <= mxr_i;
      // satp.ppn * 4K + vpn[1] * 4
      ptr_q <= {satp_ppn_i, vaddr_i[31:22], 2'b00};
    end else if (descend) begin
      // pte.ppn * 4K + vpn[0] * 4
      ptr_q <= {pte_q.ppn, ctx_q.vaddr[21:12], 2'b00};
    end
    if (r_fire) begin
      pte_q      <= ptw_pkg::pte_t'(r_data_i);
      resp_err_q <= (r_resp_i != ptw_pkg::RESP_OKAY);
    end
  end

  // --------------------
  // record, built from held registers so it stays stable in S_EMIT
  always_comb begin
    if (resp_err_q) begin
      fault = ptw_pkg::F_ACCESS;
    end else if (verdict_i == ptw_pkg::V_FAULT) begin
      fault = ptw_pkg::F_PAGE;
    end else begin
      fault = ptw_pkg::F_NONE;
    end
    rec       = '0;
    rec.pte   = pte_q;
    rec.pte.g = pte_q.g | glob_q;
    rec.vpn   = ctx_q.vaddr[31:12];
    rec.asid  = ctx_q.asid;
    rec.is_4m = (level_q == ptw_pkg::LVL1) && (fault == ptw_pkg::F_NONE);
    rec.fault = fault;
  end

  assign res.valid = (state_q == ptw_pkg::S_EMIT);
  assign res.rec   = rec;

endmodule

/* ptw_result.sv */
// one-entry result buffer between walker and TLB
// takes a new record in the same cycle the held one leaves
`timescale 1ns/10ps

module ptw_result (
  input  logic              clk_i,
  input  logic              rst_ni,
  ptw_res_if.buffer         res,
  output logic              res_valid_o,
  input  logic              res_ready_i,
  output ptw_pkg::tlb_rec_t res_rec_o
);

  logic              full_q;
  ptw_pkg::tlb_rec_t rec_q;
  logic              load;

  // free slot, or the held record drains this cycle
  assign res.ready = !full_q || res_ready_i;
  assign load      = res.valid && res.ready;

  // --------------------
  // occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (res_ready_i) begin
      full_q <= 1'b0;
    end
  end

  // payload, held while stalled
  always_ff @(posedge clk_i) begin
    if (load) begin
      rec_q <= res.rec;
    end
  end

  assign res_valid_o = full_q;
  assign res_rec_o   = rec_q;

endmodule

/* ptw_top.sv */
// Sv32 page-table walker top, miss in, AXI4-Lite reads out, TLB record out
// read-only on the bus, no PMP and no flush
`timescale 1ns/10ps

module ptw_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // miss request
  input  logic                        miss_valid_i,
  output logic                        miss_ready_o,
  input  logic [ptw_pkg::VA_W-1:0]    vaddr_i,
  input  logic [ptw_pkg::ASID_W-1:0]  asid_i,
  input  logic [ptw_pkg::PPN_W-1:0]   satp_ppn_i,
  input  logic                        is_instr_i,
  input  logic                        is_store_i,
  input  logic                        mxr_i,
  // AXI4-Lite read
  output logic                        ar_valid_o,
  input  logic                        ar_ready_i,
  output logic [ptw_pkg::PA_W-1:0]    ar_addr_o,
  input  logic                        r_valid_i,
  output logic                        r_ready_o,
  input  logic [ptw_pkg::PTE_W-1:0]   r_data_i,
  input  logic [ptw_pkg::RESP_W-1:0]  r_resp_i,
  // TLB update record
  output logic                        res_valid_o,
  input  logic                        res_ready_i,
  output ptw_pkg::pte_t               res_pte_o,
  output logic [ptw_pkg::VPN_W-1:0]   res_vpn_o,
  output logic [ptw_pkg::ASID_W-1:0]  res_asid_o,
  output logic                        res_is_4m_o,
  output ptw_pkg::fault_e             res_fault_o
);

  ptw_pkg::pte_t     pte;
  ptw_pkg::level_e   level;
  ptw_pkg::verdict_e verdict;
  ptw_pkg::tlb_rec_t rec;

  ptw_res_if res_if ();

  // --------------------
  // execute
  ptw_walk i_walk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (miss_valid_i),
    .miss_ready_o (miss_ready_o),
    .vaddr_i      (vaddr_i),
    .asid_i       (asid_i),
    .satp_ppn_i   (satp_ppn_i),
    .is_instr_i   (is_instr_i),
    .is_store_i   (is_store_i),
    .mxr_i        (mxr_i),
    .ar_valid_o   (ar_valid_o),
    .ar_ready_i   (ar_ready_i),
    .ar_addr_o    (ar_addr_o),
    .r_valid_i    (r_valid_i),
    .r_ready_o    (r_ready_o),
    .r_data_i     (r_data_i),
    .r_resp_i     (r_resp_i),
    .res          (res_if.walker),
    .verdict_i    (verdict),
    .pte_o        (pte),
    .level_o      (level)
  );

  // decode, flags come from the walk context, not the live request
  pte_decode i_decode (
    .pte_i      (pte),
    .level_i    (level),
    .is_instr_i (i_walk.ctx_q.is_instr),
    .is_store_i (i_walk.ctx_q.is_store),
    .mxr_i      (i_walk.ctx_q.mxr),
    .verdict_o  (verdict)
  );

  // result
  ptw_result i_result (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .res         (res_if.buffer),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i),
    .res_rec_o   (rec)
  );

  // split the record onto plain ports
  assign res_pte_o   = rec.pte;
  assign res_vpn_o   = rec.vpn;
  assign res_asid_o  = rec.asid;
  assign res_is_4m_o = rec.is_4m;
  assign res_fault_o = rec.fault;

endmodule

/* ptw_properties.sv */
// protocol assertions on the walker, bound into every ptw_walk
`timescale 1ns/10ps

module ptw_properties (
  input logic                 clk_i,
  input logic                 rst_ni,
  input ptw_pkg::walk_state_e state_i,
  input logic                 miss_ready_i,
  input logic                 ar_valid_i,
  input logic                 ar_ready_i,
  input logic [33:0]          ar_addr_i,
  input logic                 res_valid_i,
  input logic                 res_ready_i,
  input ptw_pkg::tlb_rec_t    rec_i
);

  // AR held with a stable address until accepted
  ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_addr_i))
    else $error("AR dropped or address changed before ARREADY");

  // ready only comes back once a walk has handed off its record
  miss_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(miss_ready_i) |->
      $past(state_i == ptw_pkg::S_IDLE) || $past(res_valid_i && res_ready_i))
    else $error("miss ready outside idle");

  // record frozen while the buffer stalls
  rec_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    res_valid_i && !res_ready_i |=> res_valid_i && $stable(rec_i))
    else $error("record changed while stalled");

endmodule

bind ptw_walk ptw_properties i_props (
  .clk_i (clk_i), .rst_ni (rst_ni), .state_i (state_q),
  .miss_ready_i (miss_ready_o), .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i), .ar_addr_i (ar_addr_o),
  .res_valid_i (res.valid), .res_ready_i (res.ready), .rec_i (rec)
);

/* tb_clock.sv */
// testbench clock, 20 ns period, reset held low for 8 cycles
`timescale 1ns/10ps

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release on a falling edge, away from the DUT sampling edge
  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

/* tb_checker.sv */
// reference Sv32 walk over the page-table memory, compares every record
// memory holds 4096 words, so only ppn[1:0] of a table pointer selects a page
`timescale 1ns/10ps

module tb_checker (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        miss_valid_i,
  input  logic        miss_ready_i,
  input  logic [31:0] vaddr_i,
  input  logic [8:0]  asid_i,
  input  logic [21:0] satp_ppn_i,
  input  logic        is_instr_i,
  input  logic        is_store_i,
  input  logic        mxr_i,
  input  logic        res_valid_i,
  input  logic        res_ready_i,
  input  logic [31:0] res_pte_i,
  input  logic [19:0] res_vpn_i,
  input  logic [8:0]  res_asid_i,
  input  logic        res_is_4m_i,
  input  logic [1:0]  res_fault_i,
  output int          done_o,
  output int          errors_o,
  output int          pending_o
);

  // page tables and the addresses that answer with SLVERR
  logic [31:0] mem [0:4095];
  logic        err [0:4095];

  logic [31:0] q_pte [$];
  logic [19:0] q_vpn [$];
  logic [8:0]  q_asid [$];
  logic        q_4m [$];
  logic [1:0]  q_fault [$];

  // 0 leaf, 1 pointer, 2 page fault
  function automatic int classify(input logic [31:0] p, input bit lvl2,
                                  input logic fetch, input logic st, input logic mx);
    logic v;
    logic r;
    logic w;
    logic x;
    logic a;
    logic d;
    v = p[0];
    r = p[1];
    w = p[2];
    x = p[3];
    a = p[6];
    d = p[7];
    if (!v || (w && !r)) return 2;
    if (!r && !x) return lvl2 ? 2 : 1;
    // leaf from here on
    if (!lvl2 && p[19:10] != 10'd0) return 2;
    if (fetch) return (x && a) ? 0 : 2;
    if (!a) return 2;
    if (!r && !(x && mx)) return 2;
    if (st && (!w || !d)) return 2;
    return 0;
  endfunction

  task automatic expect_walk(input logic [31:0] va, input logic [21:0] satp,
                             input logic fetch, input logic st, input logic mx);
    logic [11:0] idx;
    logic [31:0] word;
    logic        glob;
    int          kind;
    idx  = {satp[1:0], va[31:22]};
    word = mem[idx];
    q_vpn.push_back(va[31:12]);
    if (err[idx]) begin
      q_pte.push_back(word);
      q_4m.push_back(1'b0);
      q_fault.push_back(2'd2);
      return;
    end
    kind = classify(word, 1'b0, fetch, st, mx);
    if (kind != 1) begin
      q_pte.push_back(word);
      q_4m.push_back(kind == 0);
      q_fault.push_back(kind == 0 ? 2'd0 : 2'd1);
      return;
    end
    // second level, global bit of the root pointer carries down
    glob = word[5];
    idx  = {word[11:10], va[21:12]};
    word = mem[idx];
    word[5] = word[5] | glob;
    q_pte.push_back(word);
    q_4m.push_back(1'b0);
    if (err[idx]) begin
      q_fault.push_back(2'd2);
    end else begin
      q_fault.push_back(classify(word, 1'b1, fetch, st, mx) == 0 ? 2'd0 : 2'd1);
    end
  endtask

  task automatic compare_field(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Mismatch at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
      errors_o = errors_o + 1;
    end
  endtask

  initial begin
    done_o   = 0;
    errors_o = 0;
  end

  assign pending_o = q_pte.size();

  // DUT registers update with nonblocking writes, so posedge sees pre-edge values
  always @(posedge clk_i) begin
    if (rst_ni && miss_valid_i && miss_ready_i) begin
      q_asid.push_back(asid_i);
      expect_walk(vaddr_i, satp_ppn_i, is_instr_i, is_store_i, mxr_i);
    end
    if (rst_ni && res_valid_i && res_ready_i) begin
      if (q_pte.size() == 0) begin
        $display("unexpected record at %0t ns with no miss outstanding", $time);
        errors_o = errors_o + 1;
      end else begin
        compare_field("res_pte_o", q_pte.pop_front(), res_pte_i);
        compare_field("res_vpn_o", {12'd0, q_vpn.pop_front()}, {12'd0, res_vpn_i});
        compare_field("res_asid_o", {23'd0, q_asid.pop_front()}, {23'd0, res_asid_i});
        compare_field("res_is_4m_o", {31'd0, q_4m.pop_front()}, {31'd0, res_is_4m_i});
        compare_field("res_fault_o", {30'd0, q_fault.pop_front()}, {30'd0, res_fault_i});
        done_o = done_o + 1;
        $display("test %0d done: vpn %h fault %0d", done_o, res_vpn_i, res_fault_i);
      end
    end
  end

endmodule

/* tb_ptw.sv */
// testbench top, random page tables, random misses and AXI slave timing
// stimulus changes on the falling edge only
`timescale 1ns/10ps

module tb_ptw;

  localparam int N_TESTS    = 200;
  localparam int MEM_WORDS  = 4096;
  localparam int CYCLE_NS   = 20;
  localparam int MAX_CYCLES = N_TESTS * 60;

  integer seed = 28;

  logic        clk;
  logic        rst_n;
  logic        miss_valid;
  logic        miss_ready;
  logic [31:0] vaddr;
  logic [8:0]  asid;
  logic [21:0] satp_ppn;
  logic        is_instr;
  logic        is_store;
  logic        mxr;
  logic        ar_valid;
  logic        ar_ready;
  logic [33:0] ar_addr;
  logic        r_valid;
  logic        r_ready;
  logic [31:0] r_data;
  logic [1:0]  r_resp;
  logic        res_valid;
  logic        res_ready;
  ptw_pkg::pte_t   res_pte;
  logic [19:0]     res_vpn;
  logic [8:0]      res_asid;
  logic            res_is_4m;
  ptw_pkg::fault_e res_fault;

  // slave bookkeeping, one read outstanding
  logic        rd_pend;
  logic [33:0] rd_addr;
  int          done;
  int          errors;
  int          pending;

  tb_clock i_clock (.clk_o(clk), .rst_no(rst_n));

  ptw_top i_dut (
    .clk_i (clk), .rst_ni (rst_n),
    .miss_valid_i (miss_valid), .miss_ready_o (miss_ready),
    .vaddr_i (vaddr), .asid_i (asid), .satp_ppn_i (satp_ppn),
    .is_instr_i (is_instr), .is_store_i (is_store), .mxr_i (mxr),
    .ar_valid_o (ar_valid), .ar_ready_i (ar_ready), .ar_addr_o (ar_addr),
    .r_valid_i (r_valid), .r_ready_o (r_ready), .r_data_i (r_data), .r_resp_i (r_resp),
    .res_valid_o (res_valid), .res_ready_i (res_ready),
    .res_pte_o (res_pte), .res_vpn_o (res_vpn), .res_asid_o (res_asid),
    .res_is_4m_o (res_is_4m), .res_fault_o (res_fault)
  );

  tb_checker i_chk (
    .clk_i (clk), .rst_ni (rst_n),
    .miss_valid_i (miss_valid), .miss_ready_i (miss_ready),
    .vaddr_i (vaddr), .asid_i (asid), .satp_ppn_i (satp_ppn),
    .is_instr_i (is_instr), .is_store_i (is_store), .mxr_i (mxr),
    .res_valid_i (res_valid), .res_ready_i (res_ready),
    .res_pte_i (res_pte), .res_vpn_i (res_vpn), .res_asid_i (res_asid),
    .res_is_4m_i (res_is_4m), .res_fault_i (res_fault),
    .done_o (done), .errors_o (errors), .pending_o (pending)
  );

  // --------------------
  // page tables, mostly pointers and leaves, a few raw words
  task automatic fill_tables();
    logic [31:0] w;
    int          kind;
    for (int i = 0; i < MEM_WORDS; i++) begin
      kind = $random(seed) & 7;
      w    = $random(seed);
      if (kind < 3) begin
        // pointer into one of the four table pages, rare global
        w = {20'd0, w[1:0], 2'b00, 2'b00, ((w[9:7] == 3'd0) ? 1'b1 : 1'b0), 5'b00001};
      end else if (kind < 7) begin
        if (w[30]) w[19:10] = 10'd0;
        if (!w[1] && !w[3]) w[1] = 1'b1;
        w[0] = (w[29:27] != 3'd0);
        w[6] = w[6] | w[26];
        w[7] = w[7] | w[25];
      end
      i_chk.mem[i] = w;
      i_chk.err[i] = (($random(seed) & 31) == 0);
    end
  endtask

  // --------------------
  // AXI4-Lite read slave
  always @(posedge clk) begin
    if (!rst_n) begin
      rd_pend <= 1'b0;
      rd_addr <= '0;
    end else if (ar_valid && ar_ready) begin
      rd_addr <= ar_addr;
      rd_pend <= 1'b1;
    end else if (r_valid && r_ready) begin
      rd_pend <= 1'b0;
    end
  end

  always @(negedge clk) begin
    ar_ready  = (($random(seed) & 3) != 0);
    res_ready = (($random(seed) & 3) != 0);
    if (!rd_pend) begin
      r_valid = 1'b0;
    end else if (!r_valid && (($random(seed) & 1) != 0)) begin
      r_valid = 1'b1;
      r_data  = i_chk.mem[rd_addr[13:2]];
      r_resp  = i_chk.err[rd_addr[13:2]] ? 2'b10 : 2'b00;
    end
  end

  // --------------------
  // misses
  initial begin
    miss_valid = 1'b0;
    vaddr      = '0;
    asid       = '0;
    satp_ppn   = '0;
    is_instr   = 1'b0;
    is_store   = 1'b0;
    mxr        = 1'b0;
    ar_ready   = 1'b0;
    r_valid    = 1'b0;
    r_data     = '0;
    r_resp     = '0;
    res_ready  = 1'b0;
    fill_tables();
    wait (rst_n);
    for (int n = 0; n < N_TESTS; n++) begin
      @(negedge clk);
      miss_valid = 1'b1;
      vaddr      = $random(seed);
      asid       = $random(seed);
      satp_ppn   = {20'd0, 2'($random(seed))};
      is_instr   = (($random(seed) & 3) == 0);
      is_store   = !is_instr && (($random(seed) & 1) != 0);
      mxr        = (($random(seed) & 3) == 0);
      // ready is stable here, the transfer is on the next rising edge
      while (!miss_ready) @(negedge clk);
      @(negedge clk);
      miss_valid = 1'b0;
    end
    while (done < N_TESTS) @(negedge clk);
    repeat (20) @(negedge clk);
    if (pending != 0) begin
      $display("%0d records never came out", pending);
    end
    $display("%0d tests done, %0d errors", done, errors);
    if (errors == 0 && pending == 0 && done == N_TESTS) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(MAX_CYCLES * CYCLE_NS);
    $display("timeout after %0d cycles with %0d records seen", MAX_CYCLES, done);
    $display("Something failed");
    $finish;
  end

endmodule

/* list.f */
ptw_pkg.sv
ptw_res_if.sv
pte_decode.sv
ptw_walk.sv
ptw_result.sv
ptw_top.sv
ptw_properties.sv
tb_clock.sv
tb_checker.sv
tb_ptw.sv

/* run.sh */
#!/bin/sh
# build and run the page-table walker testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_ptw -f list.f -o tb_ptw &&
./obj_dir/tb_ptw | tee /dev/stderr | grep -q "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
